// File: project.f
eth_tx_pkg.sv
eth_skid_buf.sv
eth_tx_arb.sv
eth_axis_tx.sv
eth_tx_regs.sv
eth_tx_top.sv
tb_eth_tx.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, and judge the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_eth_tx -f project.f -o sim_tb &&
    ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Test OK" sim.log 2>/dev/null && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tb_eth_tx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eth_tx;

    import eth_tx_pkg::*;

    localparam int SEED        = 32'he1ed;
    localparam int FRAMES_MAIN = 10;
    localparam int FRAMES_EN   = 3;
    localparam int WAIT_LIMIT  = 2000;
    localparam int DRAIN_LIMIT = 5000;

    logic               clk;
    logic               rst;
    apb_req_t           apb_req;
    apb_rsp_t           apb_rsp;
    eth_hdr_t           s_hdr [NUM_SRC];
    logic [NUM_SRC-1:0] s_hdr_valid;
    logic [NUM_SRC-1:0] s_hdr_ready;
    axis_byte_t         s_beat [NUM_SRC];
    logic [NUM_SRC-1:0] s_valid;
    logic [NUM_SRC-1:0] s_ready;
    axis_byte_t         m_beat;
    logic               m_valid;
    logic               m_ready;
    logic               busy;

    integer      seed = SEED;
    int          errors = 0;
    int          checks = 0;
    int          test_num = 0;
    int          tests_failed = 0;
    logic [47:0] prog_mac;

    // expected bytes per source as {data, last, user}
    logic [9:0]  exp_q [NUM_SRC][$];
    int          frame_idx;
    int          cur_src;
    int          frames_seen;

    eth_tx_top eth_tx_top_i (
        .clk         (clk),
        .rst         (rst),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .s_hdr       (s_hdr),
        .s_hdr_valid (s_hdr_valid),
        .s_hdr_ready (s_hdr_ready),
        .s_beat      (s_beat),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .m_beat      (m_beat),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("** Error at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, want);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("failure at %0t: %s", $time, msg);
    endtask

    function automatic void push_exp(input int src, input logic [7:0] data, input logic last,
                                     input logic user);
        exp_q[src].push_back({data, last, user});
    endfunction

    function automatic int pending_bytes();
        int n;
        n = 0;
        for (int i = 0; i < NUM_SRC; i++) begin
            n += exp_q[i].size();
        end
        return n;
    endfunction

    task automatic apb_access(input bit write, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output bit slverr);
        apb_req_t req;
        int       cnt;
        bit       done;
        req.sel    = 1'b1;
        req.enable = 1'b0;
        req.write  = write;
        req.addr   = addr;
        req.wdata  = wdata;
        @(posedge clk);
        apb_req <= req;
        @(posedge clk);
        req.enable = 1'b1;
        apb_req <= req;
        done = 1'b0;
        cnt  = 0;
        while (!done && cnt < 16) begin
            @(negedge clk);
            done = apb_rsp.ready;
            cnt++;
        end
        rdata  = apb_rsp.rdata;
        slverr = apb_rsp.slverr;
        if (!done) begin
            report_failure("apb access phase never saw ready");
        end
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        bit          err;
        apb_access(1'b1, addr, data, rd, err);
        compare("apb_rsp.slverr", 64'(err), 64'(0));
    endtask

    task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
        bit err;
        apb_access(1'b0, addr, 32'h0, data, err);
        compare("apb_rsp.slverr", 64'(err), 64'(0));
    endtask

    // ready is sampled at negedge and the transfer follows on the next rising edge
    task automatic wait_ready(input int src, input bit is_hdr, output bit ok);
        int cnt;
        ok  = 1'b0;
        cnt = 0;
        while (!ok && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            if (is_hdr) begin
                ok = s_hdr_ready[src];
            end else begin
                ok = s_ready[src];
            end
            cnt++;
        end
        if (!ok) begin
            report_failure($sformatf("source %0d %s handshake timed out", src,
                                     is_hdr ? "header" : "payload"));
        end
    endtask

    task automatic send_frames(input int src, input int count);
        integer      lseed;
        logic [31:0] r0;
        logic [31:0] r1;
        eth_hdr_t    h;
        logic [7:0]  pay [16];
        logic        user;
        logic        last_b;
        int          len;
        bit          ok;
        lseed = SEED + src * 977;
        for (int f = 0; f < count; f++) begin
            r0 = $random(lseed);
            r1 = $random(lseed);
            // top byte of the destination tells the monitor the source
            h.dest_mac = {8'(src), r0[7:0], r1};
            h.eth_type = r0[23:8];
            user       = r0[24];
            len        = 1 + int'({$random(lseed)} % 16);
            for (int b = 0; b < len; b++) begin
                pay[b] = 8'($random(lseed));
            end
            for (int b = 5; b >= 0; b--) begin
                push_exp(src, h.dest_mac[b*8 +: 8], 1'b0, 1'b0);
            end
            for (int b = 5; b >= 0; b--) begin
                push_exp(src, prog_mac[b*8 +: 8], 1'b0, 1'b0);
            end
            push_exp(src, h.eth_type[15:8], 1'b0, 1'b0);
            push_exp(src, h.eth_type[7:0], 1'b0, 1'b0);
            for (int b = 0; b < len; b++) begin
                last_b = (b == len - 1);
                push_exp(src, pay[b], last_b, last_b && user);
            end
            repeat (int'({$random(lseed)} % 4)) @(posedge clk);
            @(posedge clk);
            s_hdr[src]       <= h;
            s_hdr_valid[src] <= 1'b1;
            wait_ready(src, 1'b1, ok);
            @(posedge clk);
            s_hdr_valid[src] <= 1'b0;
            if (!ok) begin
                return;
            end
            for (int b = 0; b < len && ok; b++) begin
                last_b = (b == len - 1);
                s_beat[src]  <= {pay[b], last_b, last_b && user};
                s_valid[src] <= 1'b1;
                wait_ready(src, 1'b0, ok);
                @(posedge clk);
            end
            s_valid[src] <= 1'b0;
            if (!ok) begin
                return;
            end
        end
    endtask

    task automatic take_output(input axis_byte_t b);
        logic [9:0] want;
        if (frame_idx == 0) begin
            if (int'(b.data) >= NUM_SRC) begin
                report_failure($sformatf("frame starts with unknown source 0x%0h", b.data));
                cur_src = 0;
            end else begin
                cur_src = int'(b.data);
            end
        end
        if (exp_q[cur_src].size() == 0) begin
            report_failure($sformatf("output byte with nothing expected from source %0d",
                                     cur_src));
        end else begin
            want = exp_q[cur_src].pop_front();
            compare("m_beat.data", 64'(b.data), 64'(want[9:2]));
            compare("m_beat.last", 64'(b.last), 64'(want[1]));
            compare("m_beat.user", 64'(b.user), 64'(want[0]));
        end
        if (b.last) begin
            frame_idx = 0;
            frames_seen++;
        end else begin
            frame_idx++;
        end
    endtask

    // output monitor
    initial begin
        frame_idx   = 0;
        cur_src     = 0;
        frames_seen = 0;
        forever begin
            @(negedge clk);
            if (!rst && m_valid && m_ready) begin
                take_output(m_beat);
            end
        end
    end

    // sink back-pressure with ready low about 30% of cycles
    initial begin
        integer rseed;
        rseed   = SEED ^ 32'h5a5a;
        m_ready = 1'b0;
        forever begin
            @(posedge clk);
            m_ready <= ({$random(rseed)} % 10) >= 3;
        end
    end

    task automatic wait_busy();
        int cnt;
        cnt = 0;
        while (busy !== 1'b1 && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (busy !== 1'b1) begin
            report_failure("transmitter never became busy");
        end
    endtask

    // waits until nothing is in flight in the transmitter or its output slice
    task automatic wait_quiet(input string what);
        int cnt;
        bit done;
        cnt  = 0;
        done = 1'b0;
        while (!done && cnt < DRAIN_LIMIT) begin
            @(negedge clk);
            done = !busy && !m_valid;
            cnt++;
        end
        if (!done) begin
            report_failure($sformatf("timed out waiting for %s", what));
        end
    endtask

    task automatic check_disabled_window();
        int bad;
        bad = 0;
        repeat (200) begin
            @(negedge clk);
            if (m_valid) begin
                bad++;
            end
        end
        if (bad != 0) begin
            report_failure($sformatf("m_valid was high %0d cycles with transmit disabled", bad));
        end
        if (s_hdr_valid == '0) begin
            report_failure("no header was pending while transmit was disabled");
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_num++;
        if (errors == errs_before) begin
            $display("test %0d %s: passed", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", test_num, name,
                     errors - errs_before);
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] r0;
        logic [31:0] r1;
        bit          err;
        int          errs_before;
        apb_req     = '0;
        s_hdr_valid = '0;
        s_valid     = '0;
        for (int i = 0; i < NUM_SRC; i++) begin
            s_hdr[i]  = '0;
            s_beat[i] = '0;
        end
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // reset state, then register access and a bad address
        errs_before = errors;
        @(negedge clk);
        compare("busy", 64'(busy), 64'(0));
        compare("m_valid", 64'(m_valid), 64'(0));
        compare("s_hdr_ready", 64'(s_hdr_ready), 64'(0));
        compare("s_ready", 64'(s_ready), 64'(0));
        @(posedge clk);
        reg_read(REG_CTRL, rd);
        compare("REG_CTRL", 64'(rd), 64'(0));
        reg_read(REG_FRAMES, rd);
        compare("REG_FRAMES", 64'(rd), 64'(0));
        r0 = $random(seed);
        r1 = $random(seed);
        prog_mac = {r0[15:0], r1};
        reg_write(REG_MAC_LO, prog_mac[31:0]);
        reg_write(REG_MAC_HI, {16'h0, prog_mac[47:32]});
        reg_write(REG_CTRL, 32'd1);
        reg_read(REG_MAC_LO, rd);
        compare("REG_MAC_LO", 64'(rd), 64'(prog_mac[31:0]));
        reg_read(REG_MAC_HI, rd);
        compare("REG_MAC_HI", 64'(rd), 64'(prog_mac[47:32]));
        reg_read(REG_CTRL, rd);
        compare("REG_CTRL", 64'(rd), 64'(1));
        apb_access(1'b1, 4'h1, 32'hdead_beef, rd, err);
        compare("apb_rsp.slverr", 64'(err), 64'(1));
        apb_access(1'b0, 4'h1, 32'h0, rd, err);
        compare("apb_rsp.slverr", 64'(err), 64'(1));
        reg_read(REG_MAC_LO, rd);
        compare("REG_MAC_LO", 64'(rd), 64'(prog_mac[31:0]));
        reg_read(REG_MAC_HI, rd);
        compare("REG_MAC_HI", 64'(rd), 64'(prog_mac[47:32]));
        reg_read(REG_CTRL, rd);
        compare("REG_CTRL", 64'(rd), 64'(1));
        end_test("reset and apb registers", errs_before);

        // both sources at once under random back-pressure
        errs_before = errors;
        fork
            send_frames(0, FRAMES_MAIN);
            send_frames(1, FRAMES_MAIN);
        join
        wait_quiet("all frames to leave the DUT");
        compare("pending model bytes", 64'(pending_bytes()), 64'(0));
        compare("frames seen", 64'(frames_seen), 64'(NUM_SRC * FRAMES_MAIN));
        reg_read(REG_FRAMES, rd);
        compare("REG_FRAMES", 64'(rd), 64'(frames_seen));
        end_test("frame traffic", errs_before);

        // disable mid frame and resume after a hold-off
        errs_before = errors;
        fork
            send_frames(0, FRAMES_EN);
            send_frames(1, FRAMES_EN);
            begin
                wait_busy();
                reg_write(REG_CTRL, 32'd0);
                wait_quiet("the frame in progress to end");
                check_disabled_window();
                reg_write(REG_CTRL, 32'd1);
            end
        join
        wait_quiet("pending frames to complete");
        compare("pending model bytes", 64'(pending_bytes()), 64'(0));
        compare("frames seen", 64'(frames_seen), 64'(NUM_SRC * (FRAMES_MAIN + FRAMES_EN)));
        reg_read(REG_FRAMES, rd);
        compare("REG_FRAMES", 64'(rd), 64'(frames_seen));
        end_test("enable control", errs_before);

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_num, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: eth_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module eth_tx_top (
    input  wire                             clk,
    input  wire                             rst,
    input  wire eth_tx_pkg::apb_req_t       apb_req,
    output eth_tx_pkg::apb_rsp_t            apb_rsp,
    input  wire eth_tx_pkg::eth_hdr_t       s_hdr [eth_tx_pkg::NUM_SRC],
    input  wire [eth_tx_pkg::NUM_SRC-1:0]   s_hdr_valid,
    output wire [eth_tx_pkg::NUM_SRC-1:0]   s_hdr_ready,
    input  wire eth_tx_pkg::axis_byte_t     s_beat [eth_tx_pkg::NUM_SRC],
    input  wire [eth_tx_pkg::NUM_SRC-1:0]   s_valid,
    output wire [eth_tx_pkg::NUM_SRC-1:0]   s_ready,
    output eth_tx_pkg::axis_byte_t          m_beat,
    output logic                            m_valid,
    input  wire                             m_ready,
    output logic                            busy
);

    import eth_tx_pkg::*;

    axis_byte_t         buf_beat [NUM_SRC];
    wire [NUM_SRC-1:0]  buf_valid;
    wire [NUM_SRC-1:0]  buf_ready;
    eth_hdr_t           arb_hdr;
    logic               arb_hdr_valid;
    logic               arb_hdr_ready;
    axis_byte_t         arb_beat;
    logic               arb_beat_valid;
    logic               arb_beat_ready;
    logic [47:0]        src_mac;
    logic               tx_enable;
    logic               frame_done;

    // one payload slice per source, headers bypass them
    for (genvar i = 0; i < NUM_SRC; i++) begin : g_in_buf
        eth_skid_buf #(
            .beat_t(axis_byte_t)
        ) in_buf_i (
            .clk       (clk),
            .rst       (rst),
            .in_beat   (s_beat[i]),
            .in_valid  (s_valid[i]),
            .in_ready  (s_ready[i]),
            .out_beat  (buf_beat[i]),
            .out_valid (buf_valid[i]),
            .out_ready (buf_ready[i])
        );
    end

    eth_tx_arb arb_i (
        .clk           (clk),
        .rst           (rst),
        .tx_enable     (tx_enable),
        .src_hdr       (s_hdr),
        .src_hdr_valid (s_hdr_valid),
        .src_hdr_ready (s_hdr_ready),
        .src_beat      (buf_beat),
        .src_valid     (buf_valid),
        .src_ready     (buf_ready),
        .hdr           (arb_hdr),
        .hdr_valid     (arb_hdr_valid),
        .hdr_ready     (arb_hdr_ready),
        .beat          (arb_beat),
        .beat_valid    (arb_beat_valid),
        .beat_ready    (arb_beat_ready)
    );

    eth_axis_tx tx_i (
        .clk        (clk),
        .rst        (rst),
        .src_mac    (src_mac),
        .hdr        (arb_hdr),
        .hdr_valid  (arb_hdr_valid),
        .hdr_ready  (arb_hdr_ready),
        .beat       (arb_beat),
        .beat_valid (arb_beat_valid),
        .beat_ready (arb_beat_ready),
        .m_beat     (m_beat),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .frame_done (frame_done),
        .busy       (busy)
    );

    eth_tx_regs regs_i (
        .clk        (clk),
        .rst        (rst),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .frame_done (frame_done),
        .src_mac    (src_mac),
        .tx_enable  (tx_enable)
    );

endmodule

`default_nettype wire

// File: eth_tx_regs.sv
`timescale 1ns/1ps
`default_nettype none

module eth_tx_regs (
    input  wire                       clk,
    input  wire                       rst,
    input  wire eth_tx_pkg::apb_req_t apb_req,
    output eth_tx_pkg::apb_rsp_t      apb_rsp,
    input  wire                       frame_done,
    output logic [47:0]               src_mac,
    output logic                      tx_enable
);

    import eth_tx_pkg::*;

    logic [31:0] mac_lo_q;
    logic [15:0] mac_hi_q;
    logic        enable_q;
    logic [31:0] frames_q;
    logic        access;
    logic        addr_ok;
    logic        wr_en;
    logic [31:0] rdata;

    // no wait states, every access phase completes
    assign access = apb_req.sel && apb_req.enable;
    assign wr_en  = access && apb_req.write && addr_ok;

    always_comb begin
        addr_ok = 1'b1;
        case (apb_req.addr)
            REG_MAC_LO: rdata = mac_lo_q;
            REG_MAC_HI: rdata = {16'h0, mac_hi_q};
            REG_CTRL:   rdata = {31'h0, enable_q};
            REG_FRAMES: rdata = frames_q;
            default: begin
                rdata   = '0;
                addr_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        apb_rsp.rdata  = rdata;
        apb_rsp.ready  = access;
        apb_rsp.slverr = access && !addr_ok;
    end

    assign src_mac   = {mac_hi_q, mac_lo_q};
    assign tx_enable = enable_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            mac_lo_q <= '0;
            mac_hi_q <= '0;
            enable_q <= 1'b0;
            frames_q <= '0;
        end else begin
            if (wr_en) begin
                case (apb_req.addr)
                    REG_MAC_LO: mac_lo_q <= apb_req.wdata;
                    REG_MAC_HI: mac_hi_q <= apb_req.wdata[15:0];
                    REG_CTRL:   enable_q <= apb_req.wdata[0];
                    // frame counter is read only
                    default: ;
                endcase
            end
            // wraps at 32 bits
            if (frame_done) begin
                frames_q <= frames_q + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: eth_axis_tx.sv
`timescale 1ns/1ps
`default_nettype none

module eth_axis_tx (
    input  wire                         clk,
    input  wire                         rst,
    input  wire [47:0]                  src_mac,
    input  wire eth_tx_pkg::eth_hdr_t   hdr,
    input  wire                         hdr_valid,
    output logic                        hdr_ready,
    input  wire eth_tx_pkg::axis_byte_t beat,
    input  wire                         beat_valid,
    output logic                        beat_ready,
    output eth_tx_pkg::axis_byte_t      m_beat,
    output logic                        m_valid,
    input  wire                         m_ready,
    output logic                        frame_done,
    output logic                        busy
);

    import eth_tx_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD
    } state_t;

    state_t                 state_q;
    state_t                 state_d;
    logic [HDR_PTR_W-1:0]   ptr_q;
    logic [HDR_PTR_W-1:0]   ptr_d;
    logic                   hdr_ready_q;
    logic                   hdr_ready_d;
    logic                   store_hdr;

    // latched header fields
    eth_hdr_t               hdr_q;
    logic [47:0]            src_mac_q;
    logic [HDR_BYTES-1:0][7:0] hdr_bytes;

    // feed into the output slice
    axis_byte_t             int_beat;
    logic                   int_valid;
    logic                   int_ready;
    logic                   beat_xfer;

    // wire order, byte 13 goes out first
    assign hdr_bytes = {hdr_q.dest_mac, src_mac_q, hdr_q.eth_type};

    assign hdr_ready  = hdr_ready_q;
    assign beat_ready = (state_q == ST_PAYLOAD) && int_ready;
    assign beat_xfer  = beat_valid && beat_ready;

    always_comb begin
        state_d     = state_q;
        ptr_d       = ptr_q;
        hdr_ready_d = 1'b0;
        store_hdr   = 1'b0;
        int_beat    = '0;
        int_valid   = 1'b0;
        case (state_q)
            ST_IDLE: begin
                ptr_d       = '0;
                hdr_ready_d = 1'b1;
                if (hdr_valid && hdr_ready_q) begin
                    store_hdr   = 1'b1;
                    hdr_ready_d = 1'b0;
                    state_d     = ST_HEADER;
                end
            end
            ST_HEADER: begin
                int_valid     = 1'b1;
                int_beat.data = hdr_bytes[HDR_BYTES - 1 - int'(ptr_q)];
                if (int_ready) begin
                    ptr_d = ptr_q + 1'b1;
                    if (ptr_q == HDR_PTR_W'(HDR_BYTES - 1)) begin
                        state_d = ST_PAYLOAD;
                    end
                end
            end
            ST_PAYLOAD: begin
                // pass through, last and user included
                int_valid = beat_valid;
                int_beat  = beat;
                if (beat_xfer && beat.last) begin
                    hdr_ready_d = 1'b1;
                    state_d     = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= ST_IDLE;
            ptr_q       <= '0;
            hdr_ready_q <= 1'b0;
            frame_done  <= 1'b0;
            busy        <= 1'b0;
        end else begin
            state_q     <= state_d;
            ptr_q       <= ptr_d;
            hdr_ready_q <= hdr_ready_d;
            frame_done  <= beat_xfer && beat.last;
            busy        <= state_d != ST_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (store_hdr) begin
            hdr_q     <= hdr;
            src_mac_q <= src_mac;
        end
    end

    eth_skid_buf #(
        .beat_t(axis_byte_t)
    ) out_buf_i (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (int_beat),
        .in_valid  (int_valid),
        .in_ready  (int_ready),
        .out_beat  (m_beat),
        .out_valid (m_valid),
        .out_ready (m_ready)
    );

endmodule

`default_nettype wire

// File: eth_tx_arb.sv
`timescale 1ns/1ps
`default_nettype none

module eth_tx_arb (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 tx_enable,
    input  wire eth_tx_pkg::eth_hdr_t           src_hdr [eth_tx_pkg::NUM_SRC],
    input  wire [eth_tx_pkg::NUM_SRC-1:0]       src_hdr_valid,
    output logic [eth_tx_pkg::NUM_SRC-1:0]      src_hdr_ready,
    input  wire eth_tx_pkg::axis_byte_t         src_beat [eth_tx_pkg::NUM_SRC],
    input  wire [eth_tx_pkg::NUM_SRC-1:0]       src_valid,
    output logic [eth_tx_pkg::NUM_SRC-1:0]      src_ready,
    output eth_tx_pkg::eth_hdr_t                hdr,
    output logic                                hdr_valid,
    input  wire                                 hdr_ready,
    output eth_tx_pkg::axis_byte_t              beat,
    output logic                                beat_valid,
    input  wire                                 beat_ready
);

    import eth_tx_pkg::*;

    logic             locked_q;
    // last winner, also the source held while locked
    logic [SRC_W-1:0] grant_q;
    logic [SRC_W-1:0] pick;
    logic             any_req;
    logic             hdr_xfer;
    logic             last_xfer;

    // round robin, the last winner has lowest priority
    always_comb begin
        int idx;
        pick    = grant_q;
        any_req = 1'b0;
        for (int off = NUM_SRC; off >= 1; off--) begin
            idx = (int'(grant_q) + off) % NUM_SRC;
            if (src_hdr_valid[idx]) begin
                pick    = SRC_W'(idx);
                any_req = 1'b1;
            end
        end
    end

    assign hdr       = src_hdr[pick];
    assign hdr_valid = !locked_q && tx_enable && any_req;
    assign hdr_xfer  = hdr_valid && hdr_ready;

    // payload follows the locked grant only
    assign beat       = src_beat[grant_q];
    assign beat_valid = locked_q && src_valid[grant_q];
    assign last_xfer  = beat_valid && beat_ready && beat.last;

    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            src_hdr_ready[i] = hdr_xfer && (pick == SRC_W'(i));
            src_ready[i]     = locked_q && beat_ready && (grant_q == SRC_W'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            locked_q <= 1'b0;
            grant_q  <= '0;
        end else if (hdr_xfer) begin
            locked_q <= 1'b1;
            grant_q  <= pick;
        end else if (last_xfer) begin
            locked_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: eth_skid_buf.sv
`timescale 1ns/1ps
`default_nettype none

module eth_skid_buf #(
    parameter type beat_t = logic [7:0]
) (
    input  wire        clk,
    input  wire        rst,
    input  wire beat_t in_beat,
    input  wire        in_valid,
    output logic       in_ready,
    output beat_t      out_beat,
    output logic       out_valid,
    input  wire        out_ready
);

    beat_t out_q;
    beat_t tmp_q;
    logic  out_valid_q;
    logic  out_valid_d;
    logic  tmp_valid_q;
    logic  tmp_valid_d;
    logic  ready_q;
    logic  ready_early;
    logic  load_out;
    logic  load_tmp;
    logic  tmp_to_out;

    assign in_ready  = ready_q;
    assign out_beat  = out_q;
    assign out_valid = out_valid_q;

    // ready next cycle unless the temp slot could fill up
    assign ready_early = out_ready || (!tmp_valid_q && (!out_valid_q || !in_valid));

    always_comb begin
        out_valid_d = out_valid_q;
        tmp_valid_d = tmp_valid_q;
        load_out    = 1'b0;
        load_tmp    = 1'b0;
        tmp_to_out  = 1'b0;
        if (ready_q) begin
            if (out_ready || !out_valid_q) begin
                out_valid_d = in_valid;
                load_out    = 1'b1;
            end else begin
                // output stalled, park the beat
                tmp_valid_d = in_valid;
                load_tmp    = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_d = tmp_valid_q;
            tmp_valid_d = 1'b0;
            tmp_to_out  = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
            tmp_valid_q <= 1'b0;
            ready_q     <= 1'b0;
        end else begin
            out_valid_q <= out_valid_d;
            tmp_valid_q <= tmp_valid_d;
            ready_q     <= ready_early;
        end
    end

    // payload regs
    always_ff @(posedge clk) begin
        if (load_out) begin
            out_q <= in_beat;
        end else if (tmp_to_out) begin
            out_q <= tmp_q;
        end
        if (load_tmp) begin
            tmp_q <= in_beat;
        end
    end

endmodule

`default_nettype wire

// File: eth_tx_pkg.sv
`default_nettype none

package eth_tx_pkg;

    // peer frame sources feeding the arbiter
    localparam int NUM_SRC = 2;
    localparam int SRC_W = (NUM_SRC > 1) ? $clog2(NUM_SRC) : 1;

    // dest mac + src mac + ethertype
    localparam int HDR_BYTES = 14;
    localparam int HDR_PTR_W = $clog2(HDR_BYTES);

    // apb register byte addresses
    localparam logic [3:0] REG_MAC_LO = 4'h0;
    localparam logic [3:0] REG_MAC_HI = 4'h4;
    localparam logic [3:0] REG_CTRL   = 4'h8;
    localparam logic [3:0] REG_FRAMES = 4'hC;

    // source mac is not part of this, it comes from the registers
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // one stream beat, user flags a bad frame
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } axis_byte_t;

    typedef struct packed {
        logic        sel;
        logic        enable;
        logic        write;
        logic [3:0]  addr;
        logic [31:0] wdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        ready;
        logic        slverr;
    } apb_rsp_t;

endpackage

`default_nettype wire
